// ==== Bender.yml ====
package:
  name: hc_read

sources:
  - files:
      - logic/hc_pkg.sv
      - logic/hc_frame_reader.sv
      - logic/hc_frame_writer.sv
      - logic/hc_status_mgr.sv
      - logic/hc_read_arbiter.sv
      - logic/hc_read_top.sv
  - target: test
    files:
      - dv/hc_read_tb.sv

// ==== dv/hc_read_tb.sv ====
// Table-driven testbench for the read-request path, with reference models
// of the reader, writer and status address streams
`timescale 1ns/1ns

module hc_read_tb;
    import hc_pkg::*;

    // One stimulus row with its cycle budget and expected pulse counts
    typedef struct packed {
        t_hc_csrs    csrs;
        logic        af_rand;
        logic [15:0] budget;
        logic [15:0] exp_reader;
        logic [15:0] exp_writer;
        logic [15:0] exp_status;
    } t_row;

    localparam int num_rows = 6;

    logic       clk;
    logic       reset;
    t_hc_csrs   csrs;
    logic       almost_full;
    t_read_chan tx;

    t_row   rows [num_rows];
    integer seed;
    bit     row_af_rand;
    bit     timed_out;
    int     checks;
    int     errors;
    // Totals expected for the row in flight, status is a lower bound
    int     exp_reader;
    int     exp_writer;
    int     exp_status;
    // Monitor state, cleared per row when start is seen
    int     r_cnt;
    int     w_cnt;
    int     s_cnt;
    int     exp_seq;
    int     cycle;
    int     last_status_cycle;
    bit     have_last_status;
    bit     prev_reader;
    // Channel fill and enable history for the issue gating rule
    logic   af_d1;
    logic   af_d2;
    logic   en_d1;

    hc_read_top DUT
    (
        .clk         (clk),
        .reset       (reset),
        .csrs        (csrs),
        .almost_full (almost_full),
        .tx          (tx)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input bit ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic check_rule(input bit ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("Error at time %0t: %s", $time, what);
        end
    endtask

    function automatic t_row make_row(input logic en, input logic [31:0] rbase,
        input int frames, input int lines, input logic [31:0] wbase, input int entries,
        input int interval, input logic af_rand, input int budget,
        input int exp_r, input int exp_w, input int exp_s);
        t_row r;
        r = '0;
        r.csrs.hc_en           = en;
        r.csrs.reader_base     = rbase;
        r.csrs.frame_count     = frames;
        r.csrs.lines_per_frame = lines;
        r.csrs.ring_base       = wbase;
        r.csrs.ring_entries    = entries;
        // One status line serves every row so polls across a row change stay valid
        r.csrs.status_addr     = 32'h3000_0040;
        r.csrs.poll_interval   = interval;
        r.af_rand              = af_rand;
        r.budget               = budget;
        r.exp_reader           = exp_r;
        r.exp_writer           = exp_w;
        r.exp_status           = exp_s;
        return r;
    endfunction

    // Inputs move 1 ns after the edge, almost_full follows the row's mode
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (row_af_rand)
            almost_full = (($random(seed) & 3) == 0);
        else
            almost_full = 1'b0;
    endtask

    // Reader reference: frame-major walk, one line address per pulse
    task automatic check_reader_pulse();
        int frame;
        int line;
        logic [31:0] addr;
        frame = r_cnt / csrs.lines_per_frame;
        line  = r_cnt % csrs.lines_per_frame;
        addr  = csrs.reader_base + r_cnt;
        check_rule(r_cnt < exp_reader, "reader pulsed after its last frame");
        check_value(tx.hdr.addr == addr,
            $sformatf("reader addr %h, expected %h", tx.hdr.addr, addr));
        check_value(tx.hdr.tag.frame.frame == frame && tx.hdr.tag.frame.line == line,
            $sformatf("reader tag %0d/%0d, expected %0d/%0d", tx.hdr.tag.frame.frame,
                tx.hdr.tag.frame.line, frame, line));
        // Fairness keeps the writer from starving while it has entries left
        check_rule(!(prev_reader && w_cnt < exp_writer),
            "reader won twice in a row while writer entries were waiting");
        r_cnt++;
    endtask

    // Writer reference: ring order, frame 0 and the entry as line index
    task automatic check_writer_pulse();
        logic [31:0] addr;
        addr = csrs.ring_base + w_cnt;
        check_rule(w_cnt < exp_writer, "writer pulsed after the end of its ring");
        check_value(tx.hdr.addr == addr,
            $sformatf("writer addr %h, expected %h", tx.hdr.addr, addr));
        check_value(tx.hdr.tag.frame.frame == 0 && tx.hdr.tag.frame.line == w_cnt,
            $sformatf("writer tag %0d/%0d, expected 0/%0d", tx.hdr.tag.frame.frame,
                tx.hdr.tag.frame.line, w_cnt));
        w_cnt++;
    endtask

    // Status reference: fixed line, consecutive sequence numbers
    task automatic check_status_pulse();
        check_value(tx.hdr.addr == csrs.status_addr,
            $sformatf("status addr %h, expected %h", tx.hdr.addr, csrs.status_addr));
        check_value(tx.hdr.tag.status.seq == exp_seq[13:0],
            $sformatf("status seq %0d, expected %0d", tx.hdr.tag.status.seq, exp_seq));
        check_rule(!(r_cnt < exp_reader || w_cnt < exp_writer),
            "status poll went out while frame traffic was still waiting");
        // Alone on a free channel the poll period is exactly interval + 1
        if (have_last_status && exp_reader == 0 && exp_writer == 0 && !row_af_rand)
            check_value(cycle - last_status_cycle == csrs.poll_interval + 1,
                $sformatf("status gap %0d, expected %0d", cycle - last_status_cycle,
                    csrs.poll_interval + 1));
        last_status_cycle = cycle;
        have_last_status  = 1'b1;
        exp_seq++;
        s_cnt++;
    endtask

    // Outputs are sampled on the falling edge, half a cycle from any change
    always @(negedge clk)
    begin
        if (!reset)
        begin
            cycle++;
            if (csrs.start)
            begin
                r_cnt            = 0;
                w_cnt            = 0;
                s_cnt            = 0;
                have_last_status = 1'b0;
            end
            if (tx.valid)
            begin
                check_rule(!af_d2 && en_d1,
                    "tx pulsed although the channel was full or the engine was off");
                case (tx.hdr.tag.frame.src)
                    src_reader: check_reader_pulse();
                    src_writer: check_writer_pulse();
                    src_status: check_status_pulse();
                    default:    check_rule(1'b0, "tx tag carried an unknown source");
                endcase
            end
            prev_reader = tx.valid && tx.hdr.tag.frame.src == src_reader;
            af_d2       = af_d1;
            af_d1       = almost_full;
            en_d1       = csrs.hc_en;
        end
    end

    task automatic run_row(input int idx);
        t_row r;
        int   waited;
        bit   done;
        r = rows[idx];
        // Engine off first so pulses granted under the old setup drain
        csrs.hc_en = 1'b0;
        next_cycle();
        // Rewind the requesters before the new setup reaches a pending header
        csrs.start = 1'b1;
        next_cycle();
        csrs        = r.csrs;
        csrs.hc_en  = 1'b0;
        csrs.start  = 1'b1;
        exp_reader  = r.exp_reader;
        exp_writer  = r.exp_writer;
        exp_status  = r.exp_status;
        row_af_rand = r.af_rand;
        next_cycle();
        // The engine comes up once every walk starts from its first entry
        csrs.start = 1'b0;
        csrs.hc_en = r.csrs.hc_en;
        waited = 0;
        done   = 1'b0;
        // A disabled engine is watched over its whole budget
        while (!done && waited < r.budget)
        begin
            next_cycle();
            waited++;
            done = csrs.hc_en && r_cnt >= exp_reader && w_cnt >= exp_writer &&
                s_cnt >= exp_status;
        end
        if (csrs.hc_en)
        begin
            check_rule(done, $sformatf("row %0d did not finish within %0d cycles",
                idx, r.budget));
            timed_out = !done;
        end
        repeat (4) next_cycle();
        check_value(r_cnt == exp_reader,
            $sformatf("row %0d reader count %0d, expected %0d", idx, r_cnt, exp_reader));
        check_value(w_cnt == exp_writer,
            $sformatf("row %0d writer count %0d, expected %0d", idx, w_cnt, exp_writer));
        check_value(csrs.hc_en ? s_cnt >= exp_status : s_cnt == 0,
            $sformatf("row %0d status count %0d, expected %0d", idx, s_cnt, exp_status));
    endtask

    initial
    begin : main
        int idx;
        reset       = 1'b1;
        csrs        = '0;
        almost_full = 1'b0;
        seed        = 32'he0c4b9c4;
        row_af_rand = 1'b0;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        exp_reader  = 0;
        exp_writer  = 0;
        exp_status  = 0;
        r_cnt       = 0;
        w_cnt       = 0;
        s_cnt       = 0;
        exp_seq     = 0;
        cycle       = 0;
        prev_reader = 1'b0;
        af_d1       = 1'b0;
        af_d2       = 1'b0;
        en_d1       = 1'b0;
        have_last_status  = 1'b0;
        last_status_cycle = 0;
        // Disabled engine, reader alone, reader with writer, random fill,
        // mixed traffic with status, then status alone
        rows[0] = make_row(0, 32'h0000_1000, 2, 3, 32'h0000_8000, 4, 200, 0, 60, 0, 0, 0);
        rows[1] = make_row(1, 32'h1000_0000, 3, 5, 32'h2000_0000, 0, 1000, 0, 100, 15, 0, 0);
        rows[2] = make_row(1, 32'h1000_0100, 2, 4, 32'h2000_0100, 6, 1000, 0, 100, 8, 6, 0);
        rows[3] = make_row(1, 32'h1000_0200, 4, 3, 32'h2000_0200, 5, 1000, 1, 400, 12, 5, 0);
        rows[4] = make_row(1, 32'h1000_0300, 2, 2, 32'h2000_0300, 3, 4, 0, 100, 4, 3, 1);
        rows[5] = make_row(1, 32'h1000_0400, 0, 1, 32'h2000_0400, 0, 7, 0, 100, 0, 0, 4);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (idx = 0; idx < num_rows && !timed_out; idx++)
            run_row(idx);
        $display("Checks: %0d, errors: %0d, status polls: %0d", checks, errors, exp_seq);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== logic/hc_frame_reader.sv ====
// Frame reader: walks the lines of consecutive frames and requests each one
`timescale 1ns/1ns

module hc_frame_reader
(
    input  logic                clk,
    input  logic                reset,
    input  hc_pkg::t_hc_csrs    csrs,
    input  hc_pkg::t_read_grant grant,
    output hc_pkg::t_read_req   req
);
    import hc_pkg::*;

    logic                       active;
    logic [frame_idx_width-1:0] frame;
    logic [line_idx_width-1:0]  line;
    // Frames are contiguous, so the line offset just counts up
    logic [addr_width-1:0]      offset;
    logic                       last_line;
    logic                       last_frame;

    assign last_line  = ({1'b0, line} == csrs.lines_per_frame - 1'b1);
    assign last_frame = ({1'b0, frame} == csrs.frame_count - 1'b1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            frame  <= '0;
            line   <= '0;
            offset <= '0;
        end
        // Start wins over a grant in the same cycle and rewinds the walk
        else if (csrs.start)
        begin
            active <= (csrs.frame_count != '0) && (csrs.lines_per_frame != '0);
            frame  <= '0;
            line   <= '0;
            offset <= '0;
        end
        else if (active && grant.reader_grant)
        begin
            offset <= offset + 1'b1;
            if (last_line)
            begin
                line   <= '0;
                frame  <= frame + 1'b1;
                // Request drops after the final line of the final frame
                active <= !last_frame;
            end
            else
                line <= line + 1'b1;
        end
    end

    always_comb
    begin
        req.request             = active;
        req.hdr.addr            = csrs.reader_base + offset;
        req.hdr.tag.frame.src   = src_reader;
        req.hdr.tag.frame.frame = frame;
        req.hdr.tag.frame.line  = line;
    end

    // The offered header holds until the arbiter takes it
    a_hdr_stable: assert property (@(posedge clk) disable iff (reset)
        req.request && !grant.reader_grant && !csrs.start |=> $stable(req.hdr));

endmodule

// ==== logic/hc_frame_writer.sv ====
// Frame writer: fetches each entry of the write descriptor ring in order
`timescale 1ns/1ns

module hc_frame_writer
(
    input  logic                clk,
    input  logic                reset,
    input  hc_pkg::t_hc_csrs    csrs,
    input  hc_pkg::t_read_grant grant,
    output hc_pkg::t_read_req   req
);
    import hc_pkg::*;

    logic                      active;
    logic [line_idx_width-1:0] index;
    logic                      last_entry;

    assign last_entry = ({1'b0, index} == csrs.ring_entries - 1'b1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            index  <= '0;
        end
        // An empty ring leaves the writer idle
        else if (csrs.start)
        begin
            active <= (csrs.ring_entries != '0);
            index  <= '0;
        end
        else if (active && grant.writer_grant)
        begin
            index  <= index + 1'b1;
            active <= !last_entry;
        end
    end

    // Ring entries reuse the frame view with frame 0 and the entry as line
    always_comb
    begin
        req.request             = active;
        req.hdr.addr            = csrs.ring_base + index;
        req.hdr.tag.frame.src   = src_writer;
        req.hdr.tag.frame.frame = '0;
        req.hdr.tag.frame.line  = index;
    end

endmodule

// ==== logic/hc_pkg.sv ====
// Shared types of the read-request path: CSR, request, grant and channel
// structs, the request tag union and size constants
package hc_pkg;

    localparam int addr_width      = 32;
    localparam int tag_width       = 16;
    localparam int frame_idx_width = 6;
    localparam int line_idx_width  = 8;
    localparam int seq_width       = 14;
    localparam int interval_width  = 16;

    // Requester that owns a read request
    typedef enum logic [1:0] {
        src_reader,
        src_writer,
        src_status
    } t_req_src;

    // Frame traffic carries frame and line position in the tag
    typedef struct packed {
        t_req_src                   src;
        logic [frame_idx_width-1:0] frame;
        logic [line_idx_width-1:0]  line;
    } t_tag_frame;

    // Status polls carry a running sequence number instead
    typedef struct packed {
        t_req_src             src;
        logic [seq_width-1:0] seq;
    } t_tag_status;

    // The source field lines up in both views, so it selects the view
    typedef union packed {
        t_tag_frame  frame;
        t_tag_status status;
    } t_read_tag;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        t_read_tag             tag;
    } t_read_hdr;

    // Request level plus the header it offers
    typedef struct packed {
        logic      request;
        t_read_hdr hdr;
    } t_read_req;

    typedef struct packed {
        logic can_issue;
        logic reader_grant;
        logic writer_grant;
        logic status_grant;
    } t_read_grant;

    // Count fields are one bit wider than the matching tag index
    typedef struct packed {
        logic                        hc_en;
        logic [addr_width-1:0]       reader_base;
        logic [frame_idx_width:0]    frame_count;
        logic [line_idx_width:0]     lines_per_frame;
        logic [addr_width-1:0]       ring_base;
        logic [line_idx_width:0]     ring_entries;
        logic [addr_width-1:0]       status_addr;
        logic [interval_width-1:0]   poll_interval;
        logic                        start;
    } t_hc_csrs;

    typedef struct packed {
        logic      valid;
        t_read_hdr hdr;
    } t_read_chan;

endpackage

// ==== logic/hc_read_arbiter.sv ====
// Read-request arbiter with reader/writer fairness, issue gating on enable
// and channel fill, and the registered outgoing channel word
`timescale 1ns/1ns

module hc_read_arbiter
(
    input  logic                clk,
    input  logic                reset,
    input  hc_pkg::t_hc_csrs    csrs,
    input  hc_pkg::t_read_req   reader_req,
    input  hc_pkg::t_read_req   writer_req,
    input  hc_pkg::t_read_req   status_req,
    input  logic                almost_full,
    output hc_pkg::t_read_grant grant,
    output hc_pkg::t_read_chan  tx
);
    import hc_pkg::*;

    // Channel fill as seen one cycle earlier
    logic af_q;
    logic can_issue;

    // High once the reader has just won, so the writer gets the next turn
    logic favor_writer;

    t_read_hdr hdr_sel;
    logic      valid_sel;

    // Until the first sample after reset the channel counts as full
    always_ff @(posedge clk)
    begin
        if (reset)
            af_q <= 1'b1;
        else
            af_q <= almost_full;
    end

    assign can_issue = csrs.hc_en && !af_q;

    // Fairness only tracks reader wins; any other cycle hands the turn back
    always_ff @(posedge clk)
    begin
        if (reset)
            favor_writer <= 1'b0;
        else
            favor_writer <= grant.reader_grant;
    end

    always_comb
    begin
        grant.can_issue    = can_issue;
        grant.reader_grant = 1'b0;
        grant.writer_grant = 1'b0;
        grant.status_grant = 1'b0;
        valid_sel          = 1'b0;
        // Default to the reader header so the mux needs no zero leg
        hdr_sel            = reader_req.hdr;

        // Reader wins on its turn or when the writer is quiet
        if (reader_req.request && (!favor_writer || !writer_req.request))
        begin
            grant.reader_grant = can_issue;
            valid_sel          = can_issue;
        end
        else if (writer_req.request)
        begin
            hdr_sel            = writer_req.hdr;
            grant.writer_grant = can_issue;
            valid_sel          = can_issue;
        end
        // Status polls only fill otherwise idle slots
        else if (status_req.request)
        begin
            hdr_sel            = status_req.hdr;
            grant.status_grant = can_issue;
            valid_sel          = can_issue;
        end
    end

    // The granted header leaves exactly one cycle after its grant
    always_ff @(posedge clk)
    begin
        tx.hdr <= hdr_sel;
        if (reset)
            tx.valid <= 1'b0;
        else
            tx.valid <= valid_sel;
    end

    // Only one requester may advance in a cycle
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({grant.reader_grant, grant.writer_grant, grant.status_grant}));

    // A requester never advances past a request it did not make
    a_grant_has_req: assert property (@(posedge clk) disable iff (reset)
        (!grant.reader_grant || reader_req.request) &&
        (!grant.writer_grant || writer_req.request) &&
        (!grant.status_grant || status_req.request));

    // Back-pressure and enable must hold off the channel one cycle later
    a_no_tx_when_blocked: assert property (@(posedge clk) disable iff (reset)
        !grant.can_issue |=> !tx.valid);

endmodule

// ==== logic/hc_read_top.sv ====
// Read-request path top: three requesters around the read arbiter
`timescale 1ns/1ns

module hc_read_top
(
    input  logic               clk,
    input  logic               reset,
    input  hc_pkg::t_hc_csrs   csrs,
    input  logic               almost_full,
    output hc_pkg::t_read_chan tx
);
    import hc_pkg::*;

    t_read_req   reader_req;
    t_read_req   writer_req;
    t_read_req   status_req;
    // One grant word goes to all requesters, each reads only its own bit
    t_read_grant grant;

    hc_frame_reader u_reader
    (
        .clk   (clk),
        .reset (reset),
        .csrs  (csrs),
        .grant (grant),
        .req   (reader_req)
    );

    hc_frame_writer u_writer
    (
        .clk   (clk),
        .reset (reset),
        .csrs  (csrs),
        .grant (grant),
        .req   (writer_req)
    );

    hc_status_mgr u_status
    (
        .clk   (clk),
        .reset (reset),
        .csrs  (csrs),
        .grant (grant),
        .req   (status_req)
    );

    hc_read_arbiter u_arbiter
    (
        .clk         (clk),
        .reset       (reset),
        .csrs        (csrs),
        .reader_req  (reader_req),
        .writer_req  (writer_req),
        .status_req  (status_req),
        .almost_full (almost_full),
        .grant       (grant),
        .tx          (tx)
    );

endmodule

// ==== logic/hc_status_mgr.sv ====
// Status manager: interval timer that polls one status line
`timescale 1ns/1ns

module hc_status_mgr
(
    input  logic                clk,
    input  logic                reset,
    input  hc_pkg::t_hc_csrs    csrs,
    input  hc_pkg::t_read_grant grant,
    output hc_pkg::t_read_req   req
);
    import hc_pkg::*;

    logic [interval_width-1:0] count;
    logic [seq_width-1:0]      seq;
    logic                      expired;

    // The count parks at the interval, which holds the request up
    assign expired = (count >= csrs.poll_interval);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
            seq   <= '0;
        end
        // Each granted poll restarts the interval and bumps the sequence
        else if (grant.status_grant)
        begin
            count <= '0;
            seq   <= seq + 1'b1;
        end
        else if (csrs.hc_en && !expired)
            count <= count + 1'b1;
    end

    always_comb
    begin
        req.request            = expired;
        req.hdr.addr           = csrs.status_addr;
        req.hdr.tag.status.src = src_status;
        req.hdr.tag.status.seq = seq;
    end

endmodule

// ==== project.f ====
logic/hc_pkg.sv
logic/hc_frame_reader.sv
logic/hc_frame_writer.sv
logic/hc_status_mgr.sv
logic/hc_read_arbiter.sv
logic/hc_read_top.sv
dv/hc_read_tb.sv
